/* rtl/cpu_bus_pkg.sv */
// Flat 64 KB address space, byte data, read and write data buses kept apart
`default_nettype none

package cpu_bus_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;  // Bus address
    typedef logic [DATA_W-1:0] data_t;  // Bus byte

    localparam data_t ZERO_PAGE      = 8'h00;
    localparam data_t VECTOR_PAGE_HI = 8'hFF;

    // Target low byte here, high byte at the next address
    localparam addr_t RESET_VECTOR = {VECTOR_PAGE_HI, 8'hFC};

endpackage

`default_nettype wire

/* rtl/cpu_arch_pkg.sv */
// Reduced 6502 subset only: no stack, interrupts, decimal mode or indexed modes
`default_nettype none

package cpu_arch_pkg;

    typedef enum logic [3:0] {
        RST,     // Drive reset vector low address
        JMP0,    // Target low byte arrives
        JMP1,    // Target high byte arrives, load PC
        DECODE,  // Opcode on data_in, previous result written back
        FETCH,   // Operand on data_in, ALU runs instruction op
        REG,     // Flag ops and NOPs
        ZP0,     // Zero-page address on data_in
        ABS0,    // Absolute low byte
        ABS1,    // Absolute high byte, drive full address
        BRA0,    // Offset plus PC low
        BRA1,    // Jump within page, fix high byte
        BRA2     // Page crossed
    } state_e;

    typedef enum logic [2:0] {
        OP_OR,
        OP_AND,
        OP_EOR,
        OP_ADD,
        OP_SUB,     // A + ~B + carry in
        OP_PASS_A
    } alu_op_e;

    typedef enum logic [1:0] {SEL_A, SEL_X, SEL_Y} reg_sel_e;

    typedef enum logic [2:0] {AI_ZERO, AI_REG, AI_DATA, AI_ADDR_HI, AI_RESULT} ai_sel_e;

    typedef enum logic [1:0] {BI_ZERO, BI_DATA, BI_PC_LO} bi_sel_e;

    typedef logic [2:0] cond_t;  // Opcode bits 7:5 of a branch

    localparam logic [7:0] OPC_JMP = 8'h4C;
    localparam logic [7:0] OPC_CLC = 8'h18;
    localparam logic [7:0] OPC_SEC = 8'h38;
    localparam logic [7:0] OPC_CLV = 8'hB8;

endpackage

`default_nettype wire

/* rtl/alu_ctrl_if.sv */
// ALU controls hold only for the sequencer state of the same cycle
`timescale 1ns/1ps
`default_nettype none

interface alu_ctrl_if;

    cpu_arch_pkg::alu_op_e op;      // Operation this cycle
    cpu_arch_pkg::ai_sel_e ai_sel;  // A input source
    cpu_arch_pkg::bi_sel_e bi_sel;  // B input source
    logic                  ci;      // Carry in

    modport seq (
        output op,
        output ai_sel,
        output bi_sel,
        output ci
    );

    modport alu (
        input op,
        input ai_sel,
        input bi_sel,
        input ci
    );

endinterface

`default_nettype wire

/* rtl/reg_ctrl_if.sv */
// Write and flag strobes are single-cycle and only raised in DECODE
`timescale 1ns/1ps
`default_nettype none

interface reg_ctrl_if;

    logic                   write_reg;  // Store ALU result
    cpu_arch_pkg::reg_sel_e wr_sel;     // Destination register
    cpu_arch_pkg::reg_sel_e rd_sel;     // Register on reg_out
    logic                   upd_nz;     // Load N and Z from ALU
    logic                   upd_c;      // Load C from ALU carry
    logic                   upd_v;      // Load V from ALU overflow
    logic                   set_c;
    logic                   clr_c;
    logic                   clr_v;

    modport seq (
        output write_reg, wr_sel, rd_sel,
        output upd_nz, upd_c, upd_v, set_c, clr_c, clr_v
    );

    modport regs (
        input write_reg, wr_sel, rd_sel,
        input upd_nz, upd_c, upd_v, set_c, clr_c, clr_v
    );

endinterface

`default_nettype wire

/* rtl/cpu_sequencer.sv */
// Opcodes outside the kept subset decode to REG and run as two-cycle NOPs
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  cpu_bus_pkg::data_t   data_in,
    input  logic                 alu_co,
    input  logic                 n,
    input  logic                 v,
    input  logic                 z,
    input  logic                 c,
    output cpu_arch_pkg::state_e state,
    output logic                 is_store,
    output logic                 backwards,
    alu_ctrl_if.seq              alu_ctrl,
    reg_ctrl_if.seq              reg_ctrl
);
    import cpu_arch_pkg::*;

    logic [2:0] aaa;          // Operation field
    logic [2:0] mode;         // Addressing field
    logic       grp1;         // ORA..SBC in zp, imm or abs
    logic       xy;           // LDX, LDY, STX, STY
    alu_op_e    dec_op;
    state_e     decode_next;
    logic       cond_true;
    logic       in_decode;
    logic       load_reg;     // Latched per instruction from here down
    logic       store;
    logic       load_only;
    logic       adc_sbc;
    logic       compare;
    alu_op_e    op;
    reg_sel_e   ins_reg;      // Source and destination register
    cond_t      cond;
    logic       clc;
    logic       sec;
    logic       clv;

    assign aaa       = data_in[7:5];
    assign mode      = data_in[4:2];
    assign grp1      = data_in[1:0] == 2'b01 && !mode[2] && mode != 3'b000
                       && !(aaa == 3'b100 && mode == 3'b010);  // No STA #imm
    assign xy        = data_in[7:6] == 2'b10 && !data_in[0]
                       && (mode == 3'b001 || mode == 3'b011 || (mode == 3'b000 && data_in[5]));
    assign in_decode = state == DECODE;
    assign is_store  = store;

    always_comb begin
        case (aaa)
            3'b000:         dec_op = OP_OR;
            3'b001:         dec_op = OP_AND;
            3'b010:         dec_op = OP_EOR;
            3'b011:         dec_op = OP_ADD;
            3'b110, 3'b111: dec_op = OP_SUB;  // CMP, SBC
            default:        dec_op = OP_PASS_A;  // Loads pass data through
        endcase
    end

    always_comb begin
        if (grp1 || xy) begin
            case (mode)
                3'b001:  decode_next = ZP0;
                3'b011:  decode_next = ABS0;
                default: decode_next = FETCH;  // Immediate
            endcase
        end else if (data_in == OPC_JMP) begin
            decode_next = JMP0;
        end else if (data_in[4:0] == 5'b1_0000) begin
            decode_next = BRA0;
        end else begin
            decode_next = REG;
        end
    end

    always_comb begin
        case (cond)
            3'b000:  cond_true = !n;  // BPL
            3'b001:  cond_true = n;
            3'b010:  cond_true = !v;
            3'b011:  cond_true = v;
            3'b100:  cond_true = !c;  // BCC
            3'b101:  cond_true = c;
            3'b110:  cond_true = !z;
            default: cond_true = z;   // BEQ
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RST;
        end else begin
            case (state)
                RST:     state <= JMP0;
                JMP0:    state <= JMP1;
                DECODE:  state <= decode_next;
                ZP0:     state <= FETCH;
                ABS0:    state <= ABS1;
                ABS1:    state <= FETCH;
                BRA0:    state <= cond_true ? BRA1 : DECODE;
                BRA1:    state <= (alu_co ^ backwards) ? BRA2 : DECODE;  // Page crossed
                default: state <= DECODE;  // JMP1, FETCH, REG, BRA2
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_reg <= 1'b0;
            store    <= 1'b0;
            adc_sbc  <= 1'b0;
            compare  <= 1'b0;
            clc      <= 1'b0;
            sec      <= 1'b0;
            clv      <= 1'b0;
        end else if (in_decode) begin
            load_reg <= (grp1 && aaa != 3'b100 && aaa != 3'b110) || (xy && data_in[5]);
            store    <= (grp1 && aaa == 3'b100) || (xy && !data_in[5]);
            adc_sbc  <= grp1 && aaa[1:0] == 2'b11;
            compare  <= grp1 && aaa == 3'b110;
            clc      <= data_in == OPC_CLC;
            sec      <= data_in == OPC_SEC;
            clv      <= data_in == OPC_CLV;
        end
    end

    always_ff @(posedge clk) begin
        if (in_decode) begin
            load_only <= (grp1 || xy) && aaa == 3'b101;
            op        <= dec_op;
            ins_reg   <= !xy ? SEL_A : (data_in[1] ? SEL_X : SEL_Y);
            cond      <= aaa;
        end
        if (state == BRA0) begin
            backwards <= data_in[7];  // Offset sign
        end
    end

    always_comb begin
        alu_ctrl.op     = OP_ADD;   // Default passes data low byte
        alu_ctrl.ai_sel = AI_ZERO;
        alu_ctrl.bi_sel = BI_DATA;
        alu_ctrl.ci     = 1'b0;
        case (state)
            FETCH: begin
                alu_ctrl.op     = op;
                alu_ctrl.ai_sel = load_only ? AI_DATA : AI_REG;
                alu_ctrl.ci     = compare | c;  // CMP always without borrow
            end
            REG: begin
                alu_ctrl.op     = op;
                alu_ctrl.ai_sel = AI_REG;
                alu_ctrl.bi_sel = BI_ZERO;
            end
            BRA0: begin
                alu_ctrl.ai_sel = AI_DATA;
                alu_ctrl.bi_sel = BI_PC_LO;
            end
            BRA1: begin
                alu_ctrl.op     = backwards ? OP_SUB : OP_ADD;  // High byte -1 or +1
                alu_ctrl.ai_sel = AI_ADDR_HI;
                alu_ctrl.bi_sel = BI_ZERO;
                alu_ctrl.ci     = alu_co;
            end
            DECODE, ABS1, JMP1: begin
                alu_ctrl.op     = OP_PASS_A;  // Keep result
                alu_ctrl.ai_sel = AI_RESULT;
            end
            default: begin
            end
        endcase
    end

    // Write back of the previous instruction overlaps this decode
    assign reg_ctrl.write_reg = in_decode & load_reg;
    assign reg_ctrl.wr_sel    = ins_reg;
    assign reg_ctrl.rd_sel    = ins_reg;
    assign reg_ctrl.upd_nz    = in_decode & (load_reg | compare);
    assign reg_ctrl.upd_c     = in_decode & (adc_sbc | compare);
    assign reg_ctrl.upd_v     = in_decode & adc_sbc;
    assign reg_ctrl.set_c     = in_decode & sec;
    assign reg_ctrl.clr_c     = in_decode & clc;
    assign reg_ctrl.clr_v     = in_decode & clv;

endmodule

`default_nettype wire

/* rtl/pc_counter.sv */
// PC advances by at most one per cycle; branch page fixup comes from the ALU
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
    input  logic                 clk,
    input  logic                 reset,
    input  cpu_arch_pkg::state_e state,
    input  cpu_bus_pkg::data_t   data_in,
    input  cpu_bus_pkg::data_t   alu_out,
    input  logic                 alu_co,
    input  cpu_bus_pkg::addr_t   addr_hold,
    input  logic                 backwards,
    output cpu_bus_pkg::addr_t   pc
);
    import cpu_arch_pkg::*;
    import cpu_bus_pkg::*;

    addr_t base;
    logic  inc;

    always_comb begin
        case (state)
            JMP1:    base = {data_in, alu_out};          // Jump target
            BRA1:    base = {addr_hold[15:8], alu_out};  // Same page guess
            BRA2:    base = {alu_out, pc[7:0]};          // Fixed high byte
            default: base = pc;
        endcase
    end

    always_comb begin
        case (state)
            RST, JMP1, DECODE, FETCH, ABS0, BRA0, BRA2: inc = 1'b1;
            BRA1:    inc = alu_co ~^ backwards;  // Hold on page cross
            default: inc = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else begin
            pc <= base + addr_t'(inc);
        end
    end

endmodule

`default_nettype wire

/* rtl/bus_unit.sv */
// No wait states; data_in must return the byte at the previous cycle's addr
`timescale 1ns/1ps
`default_nettype none

module bus_unit (
    input  logic                 clk,
    input  cpu_arch_pkg::state_e state,
    input  cpu_bus_pkg::addr_t   pc,
    input  cpu_bus_pkg::data_t   data_in,
    input  cpu_bus_pkg::data_t   alu_out,
    input  cpu_bus_pkg::data_t   reg_out,
    input  logic                 is_store,
    output cpu_bus_pkg::addr_t   addr,
    output cpu_bus_pkg::addr_t   addr_hold,
    output cpu_bus_pkg::data_t   data_out,
    output logic                 we
);
    import cpu_arch_pkg::*;
    import cpu_bus_pkg::*;

    always_comb begin
        case (state)
            JMP1, ABS1: addr = {data_in, alu_out};          // High byte now, low held in ALU
            ZP0:        addr = {ZERO_PAGE, data_in};
            REG:        addr = addr_hold;                   // Next opcode fetched again
            BRA1:       addr = {addr_hold[15:8], alu_out};
            BRA2:       addr = {alu_out, addr_hold[7:0]};   // Corrected page
            default:    addr = pc;
        endcase
    end

    // Last address kept for REG and the two branch halves
    always_ff @(posedge clk) begin
        addr_hold <= addr;
    end

    assign data_out = reg_out;
    assign we       = is_store && (state == ZP0 || state == ABS1);

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
// No stack pointer and no D or I flag; Z and N change only on loads and compares
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               reset,
    reg_ctrl_if.regs           reg_ctrl,
    input  cpu_bus_pkg::data_t alu_out,
    input  logic               alu_n,
    input  logic               alu_z,
    input  logic               alu_v,
    input  logic               alu_co,
    output cpu_bus_pkg::data_t reg_out,
    output logic               n,
    output logic               v,
    output logic               z,
    output logic               c
);
    import cpu_bus_pkg::*;

    data_t regs [0:2];  // A, X, Y in reg_sel_e order

    assign reg_out = regs[reg_ctrl.rd_sel];

    always_ff @(posedge clk) begin
        if (reg_ctrl.write_reg) begin
            regs[reg_ctrl.wr_sel] <= alu_out;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            n <= 1'b0;
            v <= 1'b0;
            z <= 1'b0;
            c <= 1'b0;
        end else begin
            if (reg_ctrl.upd_nz) begin
                n <= alu_n;
                z <= alu_z;
            end
            if (reg_ctrl.upd_c) begin
                c <= alu_co;  // Set means no borrow on SBC and CMP
            end else if (reg_ctrl.set_c) begin
                c <= 1'b1;
            end else if (reg_ctrl.clr_c) begin
                c <= 1'b0;
            end
            if (reg_ctrl.upd_v) begin
                v <= alu_v;
            end else if (reg_ctrl.clr_v) begin
                v <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/alu.sv */
// Binary arithmetic only; N, Z and V are captured from FETCH results alone
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic                 clk,
    input  cpu_arch_pkg::state_e state,
    alu_ctrl_if.alu              alu_ctrl,
    input  cpu_bus_pkg::data_t   reg_out,
    input  cpu_bus_pkg::data_t   data_in,
    input  cpu_bus_pkg::data_t   pc_lo,
    input  cpu_bus_pkg::data_t   addr_hi,
    output cpu_bus_pkg::data_t   alu_out,
    output logic                 alu_co,
    output logic                 alu_n,
    output logic                 alu_z,
    output logic                 alu_v
);
    import cpu_arch_pkg::*;
    import cpu_bus_pkg::*;

    data_t      a;
    data_t      b;
    data_t      b_eff;   // Inverted for SUB
    data_t      result;
    logic [8:0] sum;
    logic       arith;
    logic       ov;

    always_comb begin
        case (alu_ctrl.ai_sel)
            AI_REG:     a = reg_out;
            AI_DATA:    a = data_in;
            AI_ADDR_HI: a = addr_hi;
            AI_RESULT:  a = alu_out;
            default:    a = '0;
        endcase
    end

    always_comb begin
        case (alu_ctrl.bi_sel)
            BI_DATA:  b = data_in;
            BI_PC_LO: b = pc_lo;
            default:  b = '0;
        endcase
    end

    assign arith = alu_ctrl.op == OP_ADD || alu_ctrl.op == OP_SUB;
    assign b_eff = (alu_ctrl.op == OP_SUB) ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {8'b0, alu_ctrl.ci};
    assign ov    = arith && (a[7] == b_eff[7]) && (sum[7] != a[7]);  // Signed overflow

    always_comb begin
        case (alu_ctrl.op)
            OP_OR:          result = a | b;
            OP_AND:         result = a & b;
            OP_EOR:         result = a ^ b;
            OP_ADD, OP_SUB: result = sum[7:0];
            default:        result = a;
        endcase
    end

    always_ff @(posedge clk) begin
        alu_out <= result;
        alu_co  <= arith & sum[8];  // Branches need it from every state
        if (state == FETCH) begin
            alu_n <= result[7];
            alu_z <= result == '0;
            alu_v <= ov;
        end
    end

endmodule

`default_nettype wire

/* rtl/cpu_top.sv */
// Split read and write data buses; memory must answer reads one cycle later
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic               clk,
    input  logic               reset,
    output cpu_bus_pkg::addr_t addr,
    input  cpu_bus_pkg::data_t data_in,
    output cpu_bus_pkg::data_t data_out,
    output logic               we
);
    import cpu_arch_pkg::*;
    import cpu_bus_pkg::*;

    state_e state;
    addr_t  pc;
    addr_t  addr_hold;
    data_t  alu_out;
    data_t  reg_out;
    logic   alu_co;
    logic   alu_n;
    logic   alu_z;
    logic   alu_v;
    logic   n;
    logic   v;
    logic   z;
    logic   c;
    logic   is_store;
    logic   backwards;

    alu_ctrl_if alu_ctrl ();
    reg_ctrl_if reg_ctrl ();

    cpu_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .data_in   (data_in),
        .alu_co    (alu_co),
        .n         (n),
        .v         (v),
        .z         (z),
        .c         (c),
        .state     (state),
        .is_store  (is_store),
        .backwards (backwards),
        .alu_ctrl  (alu_ctrl.seq),
        .reg_ctrl  (reg_ctrl.seq)
    );

    pc_counter u_pc (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .data_in   (data_in),
        .alu_out   (alu_out),
        .alu_co    (alu_co),
        .addr_hold (addr_hold),
        .backwards (backwards),
        .pc        (pc)
    );

    bus_unit u_bus (
        .clk       (clk),
        .state     (state),
        .pc        (pc),
        .data_in   (data_in),
        .alu_out   (alu_out),
        .reg_out   (reg_out),
        .is_store  (is_store),
        .addr      (addr),
        .addr_hold (addr_hold),
        .data_out  (data_out),
        .we        (we)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .reg_ctrl (reg_ctrl.regs),
        .alu_out  (alu_out),
        .alu_n    (alu_n),
        .alu_z    (alu_z),
        .alu_v    (alu_v),
        .alu_co   (alu_co),
        .reg_out  (reg_out),
        .n        (n),
        .v        (v),
        .z        (z),
        .c        (c)
    );

    alu u_alu (
        .clk      (clk),
        .state    (state),
        .alu_ctrl (alu_ctrl.alu),
        .reg_out  (reg_out),
        .data_in  (data_in),
        .pc_lo    (pc[7:0]),
        .addr_hi  (addr_hold[15:8]),  // Page of the last address
        .alu_out  (alu_out),
        .alu_co   (alu_co),
        .alu_n    (alu_n),
        .alu_z    (alu_z),
        .alu_v    (alu_v)
    );

endmodule

`default_nettype wire

/* verif/cpu_sva.sv */
// Bound into cpu_top; the state check is masked while reset is high
`timescale 1ns/1ps
`default_nettype none

module cpu_sva (
    input logic        clk,
    input logic        reset,
    input logic [15:0] addr,
    input logic        we,
    input logic [3:0]  state
);

    int error_count = 0;  // Failed assertions so far

    a_we_reset: assert property (@(posedge clk) (reset || $past(reset)) |-> we !== 1'b1)
        else begin
            $error("Write strobe high during reset or right after it");
            error_count++;
        end

    a_state_code: assert property (@(posedge clk) disable iff (reset) state <= 4'd11)
        else begin
            $error("Sequencer state outside the twelve codes");
            error_count++;
        end

    // First cycle out of reset fetches the vector low byte
    a_vector_addr: assert property (@(posedge clk) $fell(reset) |-> addr == 16'hFFFC)
        else begin
            $error("First address after reset is not the vector");
            error_count++;
        end

endmodule

bind cpu_top cpu_sva u_sva (
    .clk   (clk),
    .reset (reset),
    .addr  (addr),
    .we    (we),
    .state (state)
);

`default_nettype wire

/* verif/cpu_tb.sv */
// Memory answers reads one cycle late and takes writes at the rising edge; ALU cases start at 0200
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    logic        clk;
    logic        reset;
    logic [15:0] addr;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic        we;

    logic [7:0]  mem [0:65535];
    logic [15:0] rd_addr;            // Address of the last cycle
    logic [15:0] wr_addr_q [$];      // Write log
    logic [7:0]  wr_data_q [$];

    logic [7:0]  t_opc [$];          // Case table columns
    logic        t_carry [$];
    logic [7:0]  t_a [$];
    logic [7:0]  t_b [$];
    logic [7:0]  t_br [$];
    logic [7:0]  t_res [$];
    logic        t_taken [$];
    integer      seed;

    cpu_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .we       (we)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        rd_addr <= addr;
        if (we) begin
            mem[addr] <= data_out;
            wr_addr_q.push_back(addr);
            wr_data_q.push_back(data_out);
        end
    end

    always @(negedge clk) begin
        data_in <= mem[rd_addr];  // Byte at last cycle's address
    end

    always @(negedge clk) begin
        if (u_dut.u_sva.error_count != 0) begin
            fail_run("Bus assertion failed");
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %04h actual %04h", name, expected, actual);
            fail_run("Value mismatch");
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;  // Depends on both address bytes
        end
    endtask

    // Bytes sit in the low 8*count bits, first byte highest
    task automatic load_program(input logic [15:0] start, input int count,
                                input logic [511:0] bytes);
        for (int k = 0; k < count; k++) begin
            mem[start + k] = bytes[8*(count-1-k) +: 8];
        end
    endtask

    task automatic begin_reset();
        @(negedge clk);
        reset = 1'b1;
    endtask

    task automatic end_reset(input logic [15:0] target);
        mem[16'hFFFC] = target[7:0];
        mem[16'hFFFD] = target[15:8];
        repeat (10) @(negedge clk);
        wr_addr_q.delete();
        wr_data_q.delete();
        reset = 1'b0;
        #10;
        check_value("vector low addr", 16'hFFFC, addr);
        check_value("we after reset", 16'h0, we);
        @(negedge clk);
        #10;
        check_value("vector high addr", 16'hFFFD, addr);
        check_value("we in vector fetch", 16'h0, we);
        @(negedge clk);
        #10;
        check_value("vector target addr", target, addr);
        check_value("we at first decode", 16'h0, we);
    endtask

    task automatic wait_writes(input int count, input int limit);
        int cycles;
        cycles = 0;
        while (wr_addr_q.size() < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (wr_addr_q.size() < count) begin
            fail_run("Timed out waiting for memory writes");
        end
    endtask

    task automatic add_row(input logic [7:0] opc, input logic carry, input logic [7:0] a,
                           input logic [7:0] b, input logic [7:0] br,
                           input logic [7:0] res, input logic taken);
        t_opc.push_back(opc);
        t_carry.push_back(carry);
        t_a.push_back(a);
        t_b.push_back(b);
        t_br.push_back(br);
        t_res.push_back(res);
        t_taken.push_back(taken);
    endtask

    // Reference rules for the stored byte and the branch decision
    task automatic model_row(input logic [7:0] opc, input logic carry, input logic [7:0] a,
                             input logic [7:0] b, input logic [7:0] br,
                             output logic [7:0] res, output logic taken);
        logic [8:0] sum;
        logic [7:0] flag_val;
        logic       v;
        logic       c;
        v = 1'b0;  // Cleared by CLV in the program
        c = carry;
        res = a;
        case (opc)
            8'h69: begin
                sum = a + b + carry;
                res = sum[7:0];
                c = sum[8];
                v = (a[7] == b[7]) && (res[7] != a[7]);
            end
            8'hE9: begin
                sum = a + (8'd255 - b) + carry;
                res = sum[7:0];
                c = sum[8];  // Set when no borrow
                v = (a[7] != b[7]) && (res[7] != a[7]);
            end
            8'hC9: begin
                sum = a + (8'd255 - b) + 1;
                c = sum[8];
            end
            8'h29: res = a & b;
            8'h09: res = a | b;
            default: res = a ^ b;  // EOR
        endcase
        flag_val = (opc == 8'hC9) ? sum[7:0] : res;
        case (br)
            8'h10: taken = !flag_val[7];     // BPL
            8'h30: taken = flag_val[7];
            8'h50: taken = !v;
            8'h70: taken = v;
            8'h90: taken = !c;               // BCC
            8'hB0: taken = c;
            8'hD0: taken = flag_val != 8'h00;
            default: taken = flag_val == 8'h00;  // BEQ
        endcase
    endtask

    task automatic add_random_rows(input int count);
        logic [7:0]  ops [0:5];
        logic [31:0] r;
        logic [7:0]  res;
        logic        taken;
        ops[0] = 8'h69;
        ops[1] = 8'hE9;
        ops[2] = 8'h29;
        ops[3] = 8'h09;
        ops[4] = 8'h49;
        ops[5] = 8'hC9;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            model_row(ops[r[31:8] % 6], r[3], r[15:8], r[23:16], {r[2:0], 5'b10000},
                      res, taken);
            add_row(ops[r[31:8] % 6], r[3], r[15:8], r[23:16], {r[2:0], 5'b10000},
                    res, taken);
        end
    endtask

    task automatic run_alu_case(input int i);
        begin_reset();
        load_program(16'h0200, 19, {8'hA9, t_a[i], 8'hA2, 8'h00, 8'hB8,
                     t_carry[i] ? 8'h38 : 8'h18, t_opc[i], t_b[i], 8'h85, 8'h20,
                     t_br[i], 8'h02, 8'hA2, 8'h01, 8'h86, 8'h21, 8'h4C, 8'h10, 8'h02});
        end_reset(16'h0200);
        wait_writes(2, 200);
        check_value($sformatf("row %0d result addr", i), 16'h0020, wr_addr_q[0]);
        check_value($sformatf("row %0d result", i), t_res[i], wr_data_q[0]);
        check_value($sformatf("row %0d branch addr", i), 16'h0021, wr_addr_q[1]);
        check_value($sformatf("row %0d branch", i), t_taken[i] ? 16'h0 : 16'h1, wr_data_q[1]);
    endtask

    task automatic run_address_case();
        logic [7:0] v [0:5];
        for (int k = 0; k < 6; k++) begin
            v[k] = $random(seed);
        end
        begin_reset();
        mem[16'h0040] = v[0];
        mem[16'h0041] = v[1];
        mem[16'h0042] = v[2];
        mem[16'h3110] = v[3];
        mem[16'h3111] = v[4];
        mem[16'h3112] = v[5];
        load_program(16'h0200, 36, {8'hA5, 8'h40, 8'hA6, 8'h41, 8'hA4, 8'h42,
                     8'h8D, 8'h00, 8'h30, 8'h8E, 8'h01, 8'h30, 8'h8C, 8'h02, 8'h30,
                     8'hAD, 8'h10, 8'h31, 8'hAE, 8'h11, 8'h31, 8'hAC, 8'h12, 8'h31,
                     8'h8D, 8'h03, 8'h30, 8'h8E, 8'h04, 8'h30, 8'h8C, 8'h05, 8'h30,
                     8'h4C, 8'h21, 8'h02});
        end_reset(16'h0200);
        wait_writes(6, 300);
        for (int k = 0; k < 6; k++) begin
            check_value($sformatf("store %0d addr", k), 16'h3000 + k, wr_addr_q[k]);
            check_value($sformatf("store %0d data", k), v[k], wr_data_q[k]);
        end
    endtask

    // BEQ at 0302 goes back across the page to 02F8
    task automatic run_branch_case();
        begin_reset();
        load_program(16'h02F8, 5, {8'h86, 8'h21, 8'h4C, 8'hFA, 8'h02});
        load_program(16'h0300, 11, {8'hA2, 8'h00, 8'hF0, 8'hF4, 8'hA2, 8'h05,
                     8'h86, 8'h21, 8'h4C, 8'h08, 8'h03});
        end_reset(16'h0300);
        wait_writes(1, 200);
        check_value("page cross addr", 16'h0021, wr_addr_q[0]);
        check_value("page cross data", 16'h0000, wr_data_q[0]);
        repeat (100) @(negedge clk);  // Self loop must stay quiet
        check_value("writes after self loop", 16'd1, wr_addr_q.size());
    endtask

    initial begin
        seed = 86953;
        reset = 1'b1;
        data_in = 8'h00;
        rd_addr = 16'h0000;
        fill_memory();
        add_row(8'h69, 1'b0, 8'h50, 8'h50, 8'h70, 8'hA0, 1'b1);
        add_row(8'h69, 1'b1, 8'hFF, 8'h00, 8'hB0, 8'h00, 1'b1);
        add_row(8'hE9, 1'b1, 8'h10, 8'h20, 8'h90, 8'hF0, 1'b1);
        add_row(8'hE9, 1'b0, 8'h80, 8'h01, 8'h70, 8'h7E, 1'b1);
        add_row(8'h29, 1'b0, 8'hF0, 8'h0F, 8'hD0, 8'h00, 1'b0);
        add_row(8'h09, 1'b1, 8'h01, 8'h80, 8'h10, 8'h81, 1'b0);
        add_row(8'h49, 1'b0, 8'hAA, 8'hAA, 8'hF0, 8'h00, 1'b1);
        add_row(8'hC9, 1'b0, 8'h40, 8'h40, 8'hF0, 8'h40, 1'b1);
        add_row(8'hC9, 1'b0, 8'h30, 8'h40, 8'hB0, 8'h30, 1'b0);
        add_row(8'h69, 1'b0, 8'h01, 8'h01, 8'h30, 8'h02, 1'b0);
        add_row(8'hE9, 1'b1, 8'h05, 8'h03, 8'h50, 8'h02, 1'b1);
        add_random_rows(16);
        for (int i = 0; i < t_opc.size(); i++) begin
            run_alu_case(i);
        end
        run_address_case();
        run_branch_case();
        if (u_dut.u_sva.error_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            fail_run("Bus assertion failed");
        end
    end

endmodule

`default_nettype wire

/* project.f */
rtl/cpu_bus_pkg.sv
rtl/cpu_arch_pkg.sv
rtl/alu_ctrl_if.sv
rtl/reg_ctrl_if.sv
rtl/cpu_sequencer.sv
rtl/pc_counter.sv
rtl/bus_unit.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/cpu_top.sv
verif/cpu_sva.sv
verif/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu6502_lite

sources:
  - rtl/cpu_bus_pkg.sv
  - rtl/cpu_arch_pkg.sv
  - rtl/alu_ctrl_if.sv
  - rtl/reg_ctrl_if.sv
  - rtl/cpu_sequencer.sv
  - rtl/pc_counter.sv
  - rtl/bus_unit.sv
  - rtl/reg_file.sv
  - rtl/alu.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - verif/cpu_sva.sv
      - verif/cpu_tb.sv
